/* bench/gcd_tests.txt */
# test name, tag, operand a, operand b, expected gcd
# all numbers decimal, expected gcd worked out by hand
equal_small 1 7 7 7
equal_max 2 4095 4095 4095
a_zero 3 0 25 25
b_zero 4 144 0 144
both_zero 5 0 0 0
coprime_small 6 9 4 1
coprime_fib 7 89 55 1
gcd_6 8 48 18 6
gcd_21 9 1071 462 21
power_of_two 10 1024 256 256
ones 11 1 1 1
one_and_100 12 1 100 1
primes 13 97 89 1
gcd_12 14 360 84 12
gcd_17 15 289 187 17
swapped 16 18 48 6
long_run 17 1000 999 1
gcd_100 18 4000 300 100
gcd_21_b 19 2730 231 21
gcd_7 20 35 14 7
gcd_27 21 81 27 27
a_zero_max 22 0 4095 4095
gcd_3 23 15 6 3
fib_pair 24 233 144 1

/* tb.f */
rtl/loop_types_pkg.sv
rtl/loop_ctrl_pkg.sv
rtl/loop_limiter.sv
rtl/loop_entry_merge.sv
rtl/gcd_step_pipe.sv
rtl/loop_exit_buffer.sv
rtl/gcd_loop_top.sv
bench/gcd_loop_assert.sv
bench/gcd_loop_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the gcd loop testbench with Verilator, then check the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module gcd_loop_tb -f tb.f -o gcd_loop_sim \
  && ./obj_dir/gcd_loop_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "SIMULATION PASSED" sim.log \
  && echo "run.sh: pass" \
  || { echo "run.sh: fail"; exit 1; }

/* bench/gcd_loop_tb.sv */
`timescale 1ns/1ps

module gcd_loop_tb
  import loop_types_pkg::*;
();

  localparam int MAX_TESTS = 64;
  localparam int ACCEPT_TIMEOUT = 20000;
  localparam int DRAIN_TIMEOUT = 50000;
  localparam int HOLD_CYCLES = 30;

  logic  clock = 1'b0;
  logic  resetn = 1'b0;
  logic  in_valid = 1'b0;
  tag_t  in_tag = '0;
  opnd_t in_a = '0;
  opnd_t in_b = '0;
  logic  result_stall = 1'b0;
  logic  in_stall;
  logic  result_valid;
  tag_t  result_tag;
  opnd_t result_gcd;

  string test_name [MAX_TESTS];
  tag_t  test_tag [MAX_TESTS];
  opnd_t test_a [MAX_TESTS];
  opnd_t test_b [MAX_TESTS];
  opnd_t test_gcd [MAX_TESTS];
  int    sent_count [MAX_TESTS];
  int    recv_count [MAX_TESTS];
  int    num_tests = 0;
  int    total_sent = 0;
  int    total_recv = 0;
  int    check_errors = 0;
  int    result_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    assert_fails;
  bit    timed_out = 1'b0;
  // 0 no stall, 1 held, 2 random
  int    stall_mode = 0;
  logic [31:0] rand_state = 32'h8db4_e03f;
  string phase_name = "reset";

  always #5 clock = ~clock;

  gcd_loop_top gcd_loop_top_inst (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clock)
  begin
    #1;
    if (stall_mode == 2)
    begin
      rand_state = lcg_next(rand_state);
      result_stall = rand_state[31];
    end
    else
      result_stall = (stall_mode == 1);
  end

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("Mismatch %s: expected %0b, actual %0b", name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic compare_gcd(input string name, input opnd_t expected, input opnd_t actual,
                             output bit ok);
    ok = (actual === expected);
    if (!ok)
    begin
      $display("Mismatch %s: expected gcd %0d, actual %0d", name, expected, actual);
      result_errors++;
    end
  endtask

  task automatic compare_tag(input tag_t actual, output int idx);
    idx = -1;
    for (int i = 0; i < num_tests; i++)
      if (test_tag[i] == actual && sent_count[i] > recv_count[i])
        idx = i;
    if (idx < 0)
    begin
      $display("result with tag %0d matches no outstanding test, lost or duplicated", actual);
      result_errors++;
    end
  endtask

  // a result is taken at the next rising edge
  always @(negedge clock)
  begin
    int idx;
    bit ok;
    if (resetn && result_valid && !result_stall)
    begin
      compare_tag(result_tag, idx);
      if (idx >= 0)
      begin
        compare_gcd(test_name[idx], test_gcd[idx], result_gcd, ok);
        recv_count[idx]++;
        total_recv++;
        tests_run++;
        if (!ok)
          tests_failed++;
        $display("%s %s tag %0d gcd %0d %s", phase_name, test_name[idx], result_tag,
                 result_gcd, ok ? "ok" : "wrong");
      end
    end
  end

  task automatic load_tests();
    int fd;
    int tag;
    int a;
    int b;
    int g;
    string line;
    string name;
    fd = $fopen("bench/gcd_tests.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open bench/gcd_tests.txt");
      check_errors++;
    end
    else
    begin
      // comment lines fail the scan and are skipped
      while ($fgets(line, fd) > 0 && num_tests < MAX_TESTS)
      begin
        if ($sscanf(line, "%s %d %d %d %d", name, tag, a, b, g) == 5)
        begin
          test_name[num_tests] = name;
          test_tag[num_tests] = tag_t'(tag);
          test_a[num_tests] = opnd_t'(a);
          test_b[num_tests] = opnd_t'(b);
          test_gcd[num_tests] = opnd_t'(g);
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic present_thread(input int idx);
    @(posedge clock);
    #1;
    in_valid = 1'b1;
    in_tag = test_tag[idx];
    in_a = test_a[idx];
    in_b = test_b[idx];
  endtask

  task automatic await_accept(input int idx);
    int cycles = 0;
    @(negedge clock);
    while (in_stall && cycles < ACCEPT_TIMEOUT)
    begin
      @(negedge clock);
      cycles++;
    end
    if (in_stall)
    begin
      $display("timeout, thread %s was never accepted", test_name[idx]);
      timed_out = 1'b1;
    end
    else
    begin
      sent_count[idx]++;
      total_sent++;
    end
  endtask

  task automatic release_input();
    @(posedge clock);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles = 0;
    while (total_recv < total_sent && cycles < DRAIN_TIMEOUT)
    begin
      @(posedge clock);
      cycles++;
    end
    if (total_recv < total_sent)
    begin
      $display("timeout in %s phase, %0d results never arrived", phase_name,
               total_sent - total_recv);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_tests(input string name, input bit one_at_a_time);
    phase_name = name;
    for (int i = 0; i < num_tests && !timed_out; i++)
    begin
      present_thread(i);
      await_accept(i);
      if (one_at_a_time)
      begin
        release_input();
        wait_drained();
      end
    end
    release_input();
    wait_drained();
  endtask

  // two threads fill the loop while results are held back
  task automatic check_admission();
    phase_name = "admission";
    @(negedge clock);
    stall_mode = 1;
    present_thread(0);
    await_accept(0);
    present_thread(1);
    await_accept(1);
    present_thread(2);
    repeat (HOLD_CYCLES)
    begin
      @(negedge clock);
      compare_flag("admission_in_stall", 1'b1, in_stall);
    end
    compare_flag("admission_result_valid", 1'b1, result_valid);
    stall_mode = 0;
    await_accept(2);
    release_input();
    wait_drained();
  endtask

  initial
  begin
    load_tests();
    repeat (8) @(posedge clock);
    #1;
    resetn = 1'b1;
    @(negedge clock);
    compare_flag("reset_result_valid", 1'b0, result_valid);
    compare_flag("reset_in_stall", 1'b0, in_stall);
    if (num_tests < 3)
    begin
      $display("tests file holds %0d tests, at least 3 are needed", num_tests);
      check_errors++;
    end
    else
    begin
      run_tests("single", 1'b1);
      if (!timed_out)
        run_tests("burst", 1'b0);
      if (!timed_out)
        check_admission();
      if (!timed_out)
      begin
        @(negedge clock);
        stall_mode = 2;
        run_tests("random", 1'b0);
      end
    end
    assert_fails = int'(gcd_loop_top_inst.loop_limiter_inst.limiter_checks.fail_count)
                 + int'(gcd_loop_top_inst.loop_exit_buffer_inst.buffer_checks.fail_count);
    $display("%0d results checked, %0d wrong, %0d other errors, %0d assertion failures",
             tests_run, tests_failed, check_errors + result_errors - tests_failed,
             assert_fails);
    if (check_errors == 0 && result_errors == 0 && assert_fails == 0 && !timed_out)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* bench/gcd_loop_assert.sv */
`timescale 1ns/1ps

module gcd_loop_assert
  import loop_types_pkg::*;
  import loop_ctrl_pkg::*;
(
  input logic           clock,
  input logic           resetn,
  input logic [CNT_W-1:0] count,
  input limiter_state_t state,
  input logic           entry_valid,
  input logic           exit_valid,
  input logic           exit_stall,
  input logic           result_valid,
  input logic           result_stall,
  input tag_t           result_tag,
  input opnd_t          result_gcd
);

  int unsigned fail_count = 0;

  count_in_limit: assert property (@(posedge clock) disable iff (!resetn)
    count <= CNT_W'(LOOP_LIMIT))
  else
  begin
    fail_count++;
    $error("loop count %0d above the loop limit", count);
  end

  // counter at the limit must agree with the FSM and block entry
  no_entry_when_full: assert property (@(posedge clock) disable iff (!resetn)
    (count == CNT_W'(LOOP_LIMIT)) |-> (state == FULL && !entry_valid))
  else
  begin
    fail_count++;
    $error("loop at its limit but state is not FULL or entry_valid is high");
  end

  // the limiter keeps the fifo from ever filling under a pending exit
  no_exit_stall: assert property (@(posedge clock) disable iff (!resetn)
    exit_valid |-> !exit_stall)
  else
  begin
    fail_count++;
    $error("exit_stall high while exit_valid is high");
  end

  result_held: assert property (@(posedge clock) disable iff (!resetn)
    (result_valid && result_stall) |=>
      (result_valid && $stable(result_tag) && $stable(result_gcd)))
  else
  begin
    fail_count++;
    $error("stalled result changed or dropped");
  end

endmodule

bind loop_limiter gcd_loop_assert limiter_checks (
  .clock        (clock),
  .resetn       (resetn),
  .count        (count),
  .state        (state),
  .entry_valid  (entry_valid),
  .exit_valid   (1'b0),
  .exit_stall   (1'b0),
  .result_valid (1'b0),
  .result_stall (1'b0),
  .result_tag   ('0),
  .result_gcd   ('0)
);

bind loop_exit_buffer gcd_loop_assert buffer_checks (
  .clock        (clock),
  .resetn       (resetn),
  .count        ('0),
  .state        (loop_ctrl_pkg::EMPTY),
  .entry_valid  (1'b0),
  .exit_valid   (exit_valid),
  .exit_stall   (exit_stall),
  .result_valid (result_valid),
  .result_stall (result_stall),
  .result_tag   (result_tag),
  .result_gcd   (result_gcd)
);

/* rtl/gcd_loop_top.sv */
`timescale 1ns/1ps

module gcd_loop_top
  import loop_types_pkg::*;
(
  input  logic  clock,
  input  logic  resetn,
  input  logic  in_valid,
  output logic  in_stall,
  input  tag_t  in_tag,
  input  opnd_t in_a,
  input  opnd_t in_b,
  output logic  result_valid,
  input  logic  result_stall,
  output tag_t  result_tag,
  output opnd_t result_gcd
);

  logic  entry_valid;
  logic  entry_stall;
  logic  pipe_valid;
  tag_t  pipe_tag;
  opnd_t pipe_a;
  opnd_t pipe_b;
  logic  back_valid;
  tag_t  back_tag;
  opnd_t back_a;
  opnd_t back_b;
  logic  exit_valid;
  logic  exit_stall;
  tag_t  exit_tag;
  opnd_t exit_gcd;

  // a thread counts as inside until the consumer takes its result,
  // so the exit buffer can never overflow
  loop_limiter loop_limiter_inst (
    .clock       (clock),
    .resetn      (resetn),
    .in_valid    (in_valid),
    .in_stall    (in_stall),
    .entry_valid (entry_valid),
    .entry_stall (entry_stall),
    .exit_valid  (result_valid),
    .exit_stall  (result_stall)
  );

  loop_entry_merge loop_entry_merge_inst (
    .clock       (clock),
    .resetn      (resetn),
    .entry_valid (entry_valid),
    .entry_stall (entry_stall),
    .in_tag      (in_tag),
    .in_a        (in_a),
    .in_b        (in_b),
    .back_valid  (back_valid),
    .back_tag    (back_tag),
    .back_a      (back_a),
    .back_b      (back_b),
    .pipe_valid  (pipe_valid),
    .pipe_tag    (pipe_tag),
    .pipe_a      (pipe_a),
    .pipe_b      (pipe_b)
  );

  gcd_step_pipe gcd_step_pipe_inst (
    .clock      (clock),
    .resetn     (resetn),
    .pipe_valid (pipe_valid),
    .pipe_tag   (pipe_tag),
    .pipe_a     (pipe_a),
    .pipe_b     (pipe_b),
    .back_valid (back_valid),
    .back_tag   (back_tag),
    .back_a     (back_a),
    .back_b     (back_b),
    .exit_valid (exit_valid),
    .exit_tag   (exit_tag),
    .exit_gcd   (exit_gcd)
  );

  loop_exit_buffer loop_exit_buffer_inst (
    .clock        (clock),
    .resetn       (resetn),
    .exit_valid   (exit_valid),
    .exit_stall   (exit_stall),
    .exit_tag     (exit_tag),
    .exit_gcd     (exit_gcd),
    .result_valid (result_valid),
    .result_stall (result_stall),
    .result_tag   (result_tag),
    .result_gcd   (result_gcd)
  );

endmodule

/* rtl/loop_exit_buffer.sv */
`timescale 1ns/1ps

module loop_exit_buffer
  import loop_types_pkg::*;
  import loop_ctrl_pkg::*;
(
  input  logic  clock,
  input  logic  resetn,
  input  logic  exit_valid,
  output logic  exit_stall,
  input  tag_t  exit_tag,
  input  opnd_t exit_gcd,
  output logic  result_valid,
  input  logic  result_stall,
  output tag_t  result_tag,
  output opnd_t result_gcd
);

  tag_t  tag_mem [LOOP_LIMIT];
  opnd_t gcd_mem [LOOP_LIMIT];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic write;
  logic read;

  assign exit_stall = (fill == CNT_W'(LOOP_LIMIT));
  assign result_valid = (fill != '0);
  assign result_tag = tag_mem[rd_ptr];
  assign result_gcd = gcd_mem[rd_ptr];

  assign write = exit_valid & ~exit_stall;
  assign read = result_valid & ~result_stall;

  always_ff @(posedge clock)
  begin
    if (write)
    begin
      tag_mem[wr_ptr] <= exit_tag;
      gcd_mem[wr_ptr] <= exit_gcd;
    end
  end

  // depth is a power of two, pointers wrap by themselves
  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
    end
    else
    begin
      if (write)
        wr_ptr <= wr_ptr + PTR_W'(1);
      if (read)
        rd_ptr <= rd_ptr + PTR_W'(1);
      if (write & ~read)
        fill <= fill + CNT_W'(1);
      else if (~write & read)
        fill <= fill - CNT_W'(1);
    end
  end

endmodule

/* rtl/gcd_step_pipe.sv */
`timescale 1ns/1ps

module gcd_step_pipe
  import loop_types_pkg::*;
(
  input  logic  clock,
  input  logic  resetn,
  input  logic  pipe_valid,
  input  tag_t  pipe_tag,
  input  opnd_t pipe_a,
  input  opnd_t pipe_b,
  output logic  back_valid,
  output tag_t  back_tag,
  output opnd_t back_a,
  output opnd_t back_b,
  output logic  exit_valid,
  output tag_t  exit_tag,
  output opnd_t exit_gcd
);

  logic  s1_valid;
  tag_t  s1_tag;
  opnd_t s1_a;
  opnd_t s1_b;
  logic  s1_done;
  logic  s1_a_zero;
  logic  s1_a_gt_b;

  // stage one, compare
  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      s1_valid <= 1'b0;
    else
      s1_valid <= pipe_valid;
  end

  always_ff @(posedge clock)
  begin
    s1_tag <= pipe_tag;
    s1_a <= pipe_a;
    s1_b <= pipe_b;
    s1_done <= (pipe_a == pipe_b) | (pipe_a == '0) | (pipe_b == '0);
    s1_a_zero <= (pipe_a == '0);
    s1_a_gt_b <= (pipe_a > pipe_b);
  end

  // stage two, subtract or leave the loop
  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
    begin
      back_valid <= 1'b0;
      exit_valid <= 1'b0;
    end
    else
    begin
      back_valid <= s1_valid & ~s1_done;
      exit_valid <= s1_valid & s1_done;
    end
  end

  always_ff @(posedge clock)
  begin
    back_tag <= s1_tag;
    exit_tag <= s1_tag;
    if (s1_a_gt_b)
    begin
      back_a <= s1_a - s1_b;
      back_b <= s1_b;
    end
    else
    begin
      back_a <= s1_a;
      back_b <= s1_b - s1_a;
    end
    // equal operands or b zero give a, a zero gives b
    exit_gcd <= s1_a_zero ? s1_b : s1_a;
  end

endmodule

/* rtl/loop_entry_merge.sv */
`timescale 1ns/1ps

module loop_entry_merge
  import loop_types_pkg::*;
(
  input  logic  clock,
  input  logic  resetn,
  input  logic  entry_valid,
  output logic  entry_stall,
  input  tag_t  in_tag,
  input  opnd_t in_a,
  input  opnd_t in_b,
  input  logic  back_valid,
  input  tag_t  back_tag,
  input  opnd_t back_a,
  input  opnd_t back_b,
  output logic  pipe_valid,
  output tag_t  pipe_tag,
  output opnd_t pipe_a,
  output opnd_t pipe_b
);

  // returning thread owns the slot, new thread waits
  assign entry_stall = back_valid;

  assign pipe_valid = back_valid | entry_valid;
  assign pipe_tag = back_valid ? back_tag : in_tag;
  assign pipe_a = back_valid ? back_a : in_a;
  assign pipe_b = back_valid ? back_b : in_b;

endmodule

/* rtl/loop_limiter.sv */
`timescale 1ns/1ps

module loop_limiter
  import loop_ctrl_pkg::*;
(
  input  logic clock,
  input  logic resetn,
  input  logic in_valid,
  output logic in_stall,
  output logic entry_valid,
  input  logic entry_stall,
  input  logic exit_valid,
  input  logic exit_stall
);

  limiter_state_t state;
  limiter_state_t next_state;
  logic [CNT_W-1:0] count;
  logic increment;
  logic decrement;

  // entry only while there is room in the loop
  assign entry_valid = in_valid & (state != FULL);
  assign in_stall = (state == FULL) | entry_stall;

  assign increment = entry_valid & ~entry_stall;
  assign decrement = exit_valid & ~exit_stall;

  always_comb
  begin
    next_state = state;
    case (state)
      EMPTY:
        if (increment & ~decrement)
          next_state = RUNNING;
      RUNNING:
        if (increment & ~decrement & (count == CNT_W'(LOOP_LIMIT - 1)))
          next_state = FULL;
        else if (~increment & decrement & (count == CNT_W'(1)))
          next_state = EMPTY;
      FULL:
        if (~increment & decrement)
          next_state = RUNNING;
      default:
        next_state = EMPTY;
    endcase
  end

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      state <= EMPTY;
    else
      state <= next_state;
  end

  // simultaneous entry and exit leaves the count unchanged
  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      count <= '0;
    else if (increment & ~decrement & (state != FULL))
      count <= count + CNT_W'(1);
    else if (~increment & decrement & (state != EMPTY))
      count <= count - CNT_W'(1);
  end

endmodule

/* rtl/loop_ctrl_pkg.sv */
package loop_ctrl_pkg;

  // threads allowed inside the loop, equal to the step pipe depth
  localparam int LOOP_LIMIT = 2;

  // occupancy and fill counters
  localparam int CNT_W = 2;

  // exit fifo pointers, log2 of LOOP_LIMIT
  localparam int PTR_W = 1;

  // entry conflict counter in the merge stage
  localparam int CONFLICT_W = 16;

  typedef enum logic [1:0] {
    EMPTY   = 2'b00,
    RUNNING = 2'b01,
    FULL    = 2'b10
  } limiter_state_t;

endpackage

/* rtl/loop_types_pkg.sv */
package loop_types_pkg;

  // thread identifier carried from entry to result
  localparam int TAG_W = 8;

  // width of each euclid operand and of the result
  localparam int OPND_W = 12;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [OPND_W-1:0] opnd_t;

endpackage
